/* hw/a64_isa_pkg.sv */
`default_nettype none

package a64_isa_pkg;

	// bit positions inside the 32-bit instruction word
	localparam int RD_LSB = 0;
	localparam int RN_LSB = 5;
	localparam int IMM16_LSB = 5;
	localparam int IMM12_LSB = 10;
	localparam int IMM6_LSB = 10;
	localparam int RM_LSB = 16;
	localparam int N_BIT = 21;  // logical: invert rm
	localparam int HW_LSB = 21;  // move wide: halfword select
	localparam int ADDSUB_EXT_BIT = 21;  // set for extended register form
	localparam int SH_BIT = 22;
	localparam int SHIFT_LSB = 22;
	localparam int OPC_LSB = 29;  // opc[1] = sub, opc[0] = set flags for add/sub
	localparam int SF_BIT = 31;

	// top of the group opcode field, patterns are matched downward from here
	localparam int GRP_MSB = 28;

	localparam logic [5:0] ADDSUB_IMM_MATCH = 6'b100010;  // bits 28:23
	localparam logic [4:0] ADDSUB_SHREG_MATCH = 5'b01011;  // bits 28:24
	localparam logic [4:0] LOGIC_SHREG_MATCH = 5'b01010;  // bits 28:24
	localparam logic [5:0] MOVE_WIDE_MATCH = 6'b100101;  // bits 28:23

	typedef enum logic [1:0] {
		SHIFT_LSL = 2'b00,
		SHIFT_LSR = 2'b01,
		SHIFT_ASR = 2'b10,
		SHIFT_ROR = 2'b11  // logical group only
	} shift_e;

	// same values as the opc field of the logical group
	typedef enum logic [1:0] {
		LOP_AND = 2'b00,
		LOP_ORR = 2'b01,
		LOP_EOR = 2'b10,
		LOP_ANDS = 2'b11
	} logic_op_e;

	typedef enum logic [1:0] {
		CLASS_NONE = 2'b00,
		CLASS_ARITH = 2'b01,
		CLASS_LOGIC = 2'b10,
		CLASS_MOVE = 2'b11
	} op_class_e;

endpackage

`default_nettype wire

/* hw/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	typedef logic [63:0] xword_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [5:0] shamt_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	typedef struct packed {
		a64_isa_pkg::op_class_e op_class;
		logic wide;  // sf bit, 64-bit form
		logic set_flags;
		reg_addr_t rd;
		logic use_imm;  // add/sub immediate form
		logic [12:0] imm12;  // {sh, imm12}
		a64_isa_pkg::shift_e shift;
		shamt_t shamt;
		logic subtract;
		logic invert;  // N bit of logical group
		a64_isa_pkg::logic_op_e logic_op;
		logic move_not;  // MOVN
		logic [15:0] imm16;
		logic [1:0] hw;
	} decoded_op_t;

endpackage

`default_nettype wire

/* hw/unit_result_if.sv */
`default_nettype none

interface unit_result_if;
	import exec_pkg::*;

	logic valid;  // unit owns this instruction
	xword_t result;  // already zero-extended for 32-bit forms
	logic carry;
	logic overflow;

	modport unit (
		output valid, result, carry, overflow
	);

	modport merge (
		input valid, result, carry, overflow
	);

endinterface

`default_nettype wire

/* hw/inst_decode.sv */
`default_nettype none

module inst_decode (
	input exec_pkg::inst_t inst,
	output exec_pkg::decoded_op_t dec
);
	import exec_pkg::*;
	import a64_isa_pkg::*;

	logic sf;
	logic [1:0] opc;
	logic [1:0] hw;
	shift_e shift_f;
	shamt_t shamt;
	logic bad_shamt;
	logic is_addsub_imm;
	logic is_addsub_reg;
	logic is_logic_reg;
	logic is_move;

	assign sf = inst[SF_BIT];
	assign opc = inst[OPC_LSB +: 2];
	assign hw = inst[HW_LSB +: 2];
	assign shift_f = shift_e'(inst[SHIFT_LSB +: 2]);
	assign shamt = inst[IMM6_LSB +: 6];
	assign bad_shamt = !sf && shamt[5];  // shift of 32 or more on a W register

	assign is_addsub_imm = (inst[GRP_MSB -: 6] == ADDSUB_IMM_MATCH);
	assign is_addsub_reg = (inst[GRP_MSB -: 5] == ADDSUB_SHREG_MATCH) &&
		!inst[ADDSUB_EXT_BIT];
	assign is_logic_reg = (inst[GRP_MSB -: 5] == LOGIC_SHREG_MATCH);
	assign is_move = (inst[GRP_MSB -: 6] == MOVE_WIDE_MATCH);

	always_comb begin
		// field extraction is shared, only the class and flag enable depend on the group
		dec.wide = sf;
		dec.rd = inst[RD_LSB +: 5];
		dec.imm12 = {inst[SH_BIT], inst[IMM12_LSB +: 12]};
		dec.shift = shift_f;
		dec.shamt = shamt;
		dec.subtract = opc[1];
		dec.invert = inst[N_BIT];
		dec.logic_op = logic_op_e'(opc);
		dec.move_not = (opc == 2'b00);
		dec.imm16 = inst[IMM16_LSB +: 16];
		dec.hw = hw;
		dec.use_imm = 1'b0;
		dec.set_flags = 1'b0;
		dec.op_class = CLASS_NONE;

		if (is_addsub_imm) begin
			dec.op_class = CLASS_ARITH;
			dec.use_imm = 1'b1;
			dec.set_flags = opc[0];  // ADDS / SUBS
		end else if (is_addsub_reg) begin
			if (shift_f != SHIFT_ROR && !bad_shamt) begin  // ROR is reserved here
				dec.op_class = CLASS_ARITH;
				dec.set_flags = opc[0];
			end
		end else if (is_logic_reg) begin
			if (!bad_shamt) begin
				dec.op_class = CLASS_LOGIC;
				dec.set_flags = (opc == 2'b11);  // ANDS / BICS
			end
		end else if (is_move) begin
			// opc 00 MOVN, 10 MOVZ, MOVK and 01 not handled
			if (!opc[0] && (sf || !hw[1])) begin
				dec.op_class = CLASS_MOVE;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/arith_unit.sv */
`default_nettype none

module arith_unit (
	input exec_pkg::decoded_op_t dec,
	input exec_pkg::xword_t rn_val,
	input exec_pkg::xword_t rm_val,
	unit_result_if.unit res_bus
);
	import exec_pkg::*;
	import a64_isa_pkg::*;

	xword_t imm_op;
	xword_t reg_op;
	xword_t operand_b;
	xword_t b_eff;  // operand after optional inversion
	logic [64:0] sum65;
	logic [32:0] sum33;
	logic a_sign;
	logic b_sign;
	logic r_sign;

	assign imm_op = dec.imm12[12] ? {40'b0, dec.imm12[11:0], 12'b0} :
		{52'b0, dec.imm12[11:0]};

	always_comb begin
		if (dec.wide) begin
			case (dec.shift)
				SHIFT_LSR: reg_op = rm_val >> dec.shamt;
				SHIFT_ASR: reg_op = $signed(rm_val) >>> dec.shamt;
				default: reg_op = rm_val << dec.shamt;  // LSL, ROR never reaches here
			endcase
		end else begin
			case (dec.shift)
				SHIFT_LSR: reg_op = {32'b0, rm_val[31:0] >> dec.shamt[4:0]};
				SHIFT_ASR: reg_op = {32'b0, $signed(rm_val[31:0]) >>> dec.shamt[4:0]};
				default: reg_op = {32'b0, rm_val[31:0] << dec.shamt[4:0]};
			endcase
		end
	end

	assign operand_b = dec.use_imm ? imm_op : reg_op;

	// subtract as rn + ~b + 1, so carry out means no borrow
	assign b_eff = dec.subtract ? ~operand_b : operand_b;
	assign sum65 = {1'b0, rn_val} + {1'b0, b_eff} + 65'(dec.subtract);
	assign sum33 = {1'b0, rn_val[31:0]} + {1'b0, b_eff[31:0]} + 33'(dec.subtract);

	assign a_sign = dec.wide ? rn_val[63] : rn_val[31];
	assign b_sign = dec.wide ? b_eff[63] : b_eff[31];
	assign r_sign = dec.wide ? sum65[63] : sum33[31];

	assign res_bus.valid = (dec.op_class == CLASS_ARITH);
	assign res_bus.result = dec.wide ? sum65[63:0] : {32'b0, sum33[31:0]};
	assign res_bus.carry = dec.wide ? sum65[64] : sum33[32];
	assign res_bus.overflow = (a_sign == b_sign) && (r_sign != a_sign);  // same-sign inputs

endmodule

`default_nettype wire

/* hw/logic_unit.sv */
`default_nettype none

module logic_unit (
	input exec_pkg::decoded_op_t dec,
	input exec_pkg::xword_t rn_val,
	input exec_pkg::xword_t rm_val,
	unit_result_if.unit res_bus
);
	import exec_pkg::*;
	import a64_isa_pkg::*;

	xword_t shifted;
	xword_t operand_b;
	xword_t logic_res;
	xword_t move_raw;
	xword_t move_res;
	xword_t full_res;

	always_comb begin
		if (dec.wide) begin
			case (dec.shift)
				SHIFT_LSL: shifted = rm_val << dec.shamt;
				SHIFT_LSR: shifted = rm_val >> dec.shamt;
				SHIFT_ASR: shifted = $signed(rm_val) >>> dec.shamt;
				default: shifted = 64'({rm_val, rm_val} >> dec.shamt);  // ror
			endcase
		end else begin
			case (dec.shift)
				SHIFT_LSL: shifted = {32'b0, rm_val[31:0] << dec.shamt[4:0]};
				SHIFT_LSR: shifted = {32'b0, rm_val[31:0] >> dec.shamt[4:0]};
				SHIFT_ASR: shifted = {32'b0, $signed(rm_val[31:0]) >>> dec.shamt[4:0]};
				default: shifted = {32'b0, 32'({rm_val[31:0], rm_val[31:0]} >> dec.shamt[4:0])};
			endcase
		end
	end

	assign operand_b = dec.invert ? ~shifted : shifted;  // BIC, ORN, EON, BICS

	always_comb begin
		case (dec.logic_op)
			LOP_ORR: logic_res = rn_val | operand_b;
			LOP_EOR: logic_res = rn_val ^ operand_b;
			default: logic_res = rn_val & operand_b;  // AND and ANDS
		endcase
	end

	assign move_raw = {48'b0, dec.imm16} << {dec.hw, 4'b0000};  // hw * 16
	assign move_res = dec.move_not ? ~move_raw : move_raw;

	assign full_res = (dec.op_class == CLASS_MOVE) ? move_res : logic_res;

	// 32-bit forms write a zero-extended W result
	assign res_bus.result = dec.wide ? full_res : {32'b0, full_res[31:0]};
	assign res_bus.valid = (dec.op_class == CLASS_LOGIC) || (dec.op_class == CLASS_MOVE);
	assign res_bus.carry = 1'b0;
	assign res_bus.overflow = 1'b0;

endmodule

`default_nettype wire

/* hw/result_merge.sv */
`default_nettype none

module result_merge (
	input logic clock,
	input logic rst,
	input exec_pkg::decoded_op_t dec,
	unit_result_if.merge arith_bus,
	unit_result_if.merge logic_bus,
	output exec_pkg::xword_t res,
	output logic wr_en,
	output exec_pkg::reg_addr_t wr_addr,
	output logic wide,
	output exec_pkg::flags_t flags
);
	import exec_pkg::*;

	xword_t sel_res;
	logic sel_valid;
	logic sel_carry;
	logic sel_overflow;
	logic res_n;
	logic res_z;
	flags_t flag_q;

	// at most one unit claims an instruction
	assign sel_res = arith_bus.valid ? arith_bus.result : logic_bus.result;
	assign sel_carry = arith_bus.valid ? arith_bus.carry : logic_bus.carry;
	assign sel_overflow = arith_bus.valid ? arith_bus.overflow : logic_bus.overflow;
	assign sel_valid = arith_bus.valid | logic_bus.valid;

	assign res_n = dec.wide ? sel_res[63] : sel_res[31];
	assign res_z = dec.wide ? (sel_res == '0) : (sel_res[31:0] == '0);

	assign res = sel_res;
	assign wr_en = sel_valid;
	assign wr_addr = dec.rd;
	assign wide = dec.wide;

	always_ff @(posedge clock) begin
		if (rst) begin
			flag_q <= '0;
		end else if (sel_valid && dec.set_flags) begin  // hold otherwise
			flag_q.n <= res_n;
			flag_q.z <= res_z;
			flag_q.c <= sel_carry;
			flag_q.v <= sel_overflow;
		end
	end

	assign flags = flag_q;

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`default_nettype none

module exec_stage (
	input logic clock,
	input logic rst,
	input exec_pkg::inst_t inst,
	input exec_pkg::xword_t rn_val,
	input exec_pkg::xword_t rm_val,
	output exec_pkg::xword_t res,
	output logic wr_en,
	output exec_pkg::reg_addr_t wr_addr,
	output logic wide,
	output logic flag_n,
	output logic flag_z,
	output logic flag_c,
	output logic flag_v
);
	import exec_pkg::*;

	decoded_op_t dec;
	flags_t flags;

	unit_result_if arith_res ();
	unit_result_if logic_res ();

	inst_decode decode_i (
		.inst(inst),
		.dec(dec)
	);

	arith_unit arith_i (
		.dec(dec),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.res_bus(arith_res)
	);

	logic_unit logic_i (
		.dec(dec),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.res_bus(logic_res)
	);

	result_merge merge_i (
		.clock(clock),
		.rst(rst),
		.dec(dec),
		.arith_bus(arith_res),
		.logic_bus(logic_res),
		.res(res),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wide(wide),
		.flags(flags)
	);

	assign flag_n = flags.n;
	assign flag_z = flags.z;
	assign flag_c = flags.c;
	assign flag_v = flags.v;

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`default_nettype none

module clock_gen (
	output logic clock
);
	localparam int half_period = 50;  // 100 unit period

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

endmodule

`default_nettype wire

/* tb/exec_stage_asserts.sv */
`default_nettype none

module exec_stage_asserts (
	input logic clock,
	input logic rst,
	input logic arith_valid,
	input logic logic_valid,
	input logic set_flags,
	input logic wr_en,
	input exec_pkg::reg_addr_t wr_addr,
	input exec_pkg::flags_t flags
);

	int failures = 0;  // failed assertion count

	one_unit: assert property (@(posedge clock) !(arith_valid && logic_valid))
		else begin
			failures++;
			$error("arith and logic units both claim the instruction");
		end

	// flags only move on a valid flag-setting instruction
	flags_hold: assert property (@(posedge clock)
		!rst && !(wr_en && set_flags) |=> $stable(flags))
		else begin
			failures++;
			$error("flags changed without a flag-setting instruction");
		end

	flags_reset: assert property (@(posedge clock) rst |=> flags == '0)
		else begin
			failures++;
			$error("flags not cleared by reset");
		end

	addr_known: assert property (@(posedge clock) wr_en |-> !$isunknown(wr_addr))
		else begin
			failures++;
			$error("write address has unknown bits during a write");
		end

endmodule

`default_nettype wire

/* tb/exec_stage_tb.sv */
`default_nettype none

module exec_stage_tb;
	import exec_pkg::*;
	import a64_isa_pkg::*;

	// add/sub 20, flag setting 8, logical 64, moves 12, unsupported 9
	localparam int num_instr = 20 + 8 + 64 + 12 + 9;
	localparam int watchdog_time = (8 + num_instr) * 2 * 100 + 2000;

	logic clock;
	logic rst;
	inst_t inst;
	xword_t rn_val;
	xword_t rm_val;
	xword_t res;
	logic wr_en;
	reg_addr_t wr_addr;
	logic wide;
	logic flag_n;
	logic flag_z;
	logic flag_c;
	logic flag_v;

	flags_t model_flags;  // expected flag register
	int errors;
	int checks;
	int tests;

	clock_gen clock_gen_i (.clock(clock));

	exec_stage exec_stage_i (
		.clock(clock),
		.rst(rst),
		.inst(inst),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.res(res),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wide(wide),
		.flag_n(flag_n),
		.flag_z(flag_z),
		.flag_c(flag_c),
		.flag_v(flag_v)
	);

	bind result_merge exec_stage_asserts asserts_i (
		.clock(clock),
		.rst(rst),
		.arith_valid(arith_bus.valid),
		.logic_valid(logic_bus.valid),
		.set_flags(dec.set_flags),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.flags(flags)
	);

	// instruction encoders use x1 as rn and x2 as rm
	function automatic inst_t enc_addsub_imm(input logic sf, input logic sub, input logic s,
		input logic sh, input logic [11:0] imm, input reg_addr_t rd);
		return {sf, sub, s, 6'b100010, sh, imm, 5'd1, rd};
	endfunction

	function automatic inst_t enc_addsub_reg(input logic sf, input logic sub, input logic s,
		input shift_e sh, input shamt_t amt, input reg_addr_t rd);
		return {sf, sub, s, 5'b01011, sh, 1'b0, 5'd2, amt, 5'd1, rd};
	endfunction

	function automatic inst_t enc_logic(input logic sf, input logic [1:0] opc,
		input shift_e sh, input logic n, input shamt_t amt, input reg_addr_t rd);
		return {sf, opc, 5'b01010, sh, n, 5'd2, amt, 5'd1, rd};
	endfunction

	function automatic inst_t enc_move(input logic sf, input logic [1:0] opc,
		input logic [1:0] hw, input logic [15:0] imm, input reg_addr_t rd);
		return {sf, opc, 6'b100101, hw, imm, rd};
	endfunction

	function automatic xword_t rand_word();
		return {$urandom, $urandom};
	endfunction

	function automatic reg_addr_t rand_reg();
		return 5'($urandom);
	endfunction

	function automatic shamt_t rand_amt(input logic w);
		return w ? 6'($urandom) : {1'b0, 5'($urandom)};
	endfunction

	function automatic xword_t model_shift(input logic w, input shift_e sh, input shamt_t amt,
		input xword_t val);
		logic [31:0] lo;
		logic [31:0] r32;
		xword_t r;
		lo = val[31:0];
		if (w) begin
			case (sh)
				SHIFT_LSL: r = val << amt;
				SHIFT_LSR: r = val >> amt;
				SHIFT_ASR: r = $signed(val) >>> amt;
				default: r = (val >> amt) | (val << (7'd64 - {1'b0, amt}));
			endcase
		end else begin
			case (sh)
				SHIFT_LSL: r32 = lo << amt[4:0];
				SHIFT_LSR: r32 = lo >> amt[4:0];
				SHIFT_ASR: r32 = $signed(lo) >>> amt[4:0];
				default: r32 = (lo >> amt[4:0]) | (lo << (6'd32 - {1'b0, amt[4:0]}));
			endcase
			r = {32'b0, r32};
		end
		return r;
	endfunction

	function automatic void model_addsub(input logic w, input logic sub, input xword_t a,
		input xword_t b, output xword_t r, output flags_t f);
		int msb;
		msb = w ? 63 : 31;
		if (!w) begin
			a = {32'b0, a[31:0]};
			b = {32'b0, b[31:0]};
		end
		r = sub ? a - b : a + b;
		if (!w)
			r[63:32] = '0;
		f.n = r[msb];
		f.z = (r == '0);
		f.c = sub ? (a >= b) : (r < a);  // no borrow / unsigned wrap
		if (sub)
			f.v = (a[msb] != b[msb]) && (r[msb] != a[msb]);
		else
			f.v = (a[msb] == b[msb]) && (r[msb] != a[msb]);
	endfunction

	task automatic check_word(input string what, input xword_t got, input xword_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flags(input string what, input flags_t got, input flags_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got nzcv %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int e0);
		tests++;
		if (errors == e0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - e0);
	endtask

	// drive one instruction, check the same-cycle outputs, then the flags after the edge
	task automatic run_inst(input string name, input inst_t i, input reg_addr_t rd,
		input logic w, input xword_t a, input xword_t b, input logic exp_en,
		input xword_t exp_res, input logic exp_set, input flags_t exp_f);
		inst = i;
		rn_val = a;
		rm_val = b;
		@(negedge clock);
		check_bit({name, " wr_en"}, wr_en, exp_en);
		if (exp_en) begin
			check_word({name, " res"}, res, exp_res);
			check_addr({name, " wr_addr"}, wr_addr, rd);
			check_bit({name, " wide"}, wide, w);
		end
		if (exp_set)
			model_flags = exp_f;
		@(posedge clock);
		#5;
		check_flags({name, " flags"}, flags_t'({flag_n, flag_z, flag_c, flag_v}), model_flags);
	endtask

	task automatic arith_imm(input string name, input logic w, input logic sub,
		input logic setf, input logic sh, input logic [11:0] imm, input xword_t a);
		xword_t op;
		xword_t r;
		flags_t f;
		reg_addr_t rd;
		op = xword_t'(imm) << (sh ? 12 : 0);
		rd = rand_reg();
		model_addsub(w, sub, a, op, r, f);
		run_inst(name, enc_addsub_imm(w, sub, setf, sh, imm, rd), rd, w, a, rand_word(),
			1'b1, r, setf, f);
	endtask

	task automatic arith_reg(input string name, input logic w, input logic sub,
		input logic setf, input shift_e sh, input shamt_t amt, input xword_t a, input xword_t b);
		xword_t r;
		flags_t f;
		reg_addr_t rd;
		rd = rand_reg();
		model_addsub(w, sub, a, model_shift(w, sh, amt, b), r, f);
		run_inst(name, enc_addsub_reg(w, sub, setf, sh, amt, rd), rd, w, a, b, 1'b1, r, setf,
			f);
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		model_flags = '0;
		check_flags("reset flags", flags_t'({flag_n, flag_z, flag_c, flag_v}), model_flags);
		report_test("reset", e0);
	endtask

	task automatic test_add_sub();
		int e0;
		e0 = errors;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < 2; s++) begin
				for (int sh = 0; sh < 2; sh++)
					arith_imm($sformatf("add/sub imm w%0d s%0d sh%0d", w, s, sh), w[0], s[0],
						1'b0, sh[0], 12'($urandom), rand_word());
				for (int k = 0; k < 3; k++)  // no ROR here
					arith_reg($sformatf("add/sub reg w%0d s%0d k%0d", w, s, k), w[0], s[0],
						1'b0, shift_e'(k), rand_amt(w[0]), rand_word(), rand_word());
			end
		end
		report_test("add/sub", e0);
	endtask

	task automatic test_flag_set();
		int e0;
		xword_t a;
		e0 = errors;
		for (int w = 0; w < 2; w++) begin
			arith_reg("adds reg", w[0], 1'b0, 1'b1, SHIFT_LSL, rand_amt(w[0]), rand_word(),
				rand_word());
			arith_imm("subs imm", w[0], 1'b1, 1'b1, 1'b0, 12'($urandom), rand_word());
			a = rand_word();
			arith_reg("subs equal", w[0], 1'b1, 1'b1, SHIFT_LSL, 6'd0, a, a);  // z and c
			a = w ? 64'h7fff_ffff_ffff_ffff : {32'($urandom), 32'h7fff_ffff};
			arith_imm("adds overflow", w[0], 1'b0, 1'b1, 1'b0, 12'd1, a);
		end
		report_test("adds/subs", e0);
	endtask

	task automatic test_logic();
		int e0;
		xword_t a;
		xword_t b;
		xword_t r;
		flags_t f;
		shamt_t amt;
		reg_addr_t rd;
		e0 = errors;
		for (int w = 0; w < 2; w++) begin
			for (int opc = 0; opc < 4; opc++) begin
				for (int n = 0; n < 2; n++) begin
					for (int k = 0; k < 4; k++) begin
						a = rand_word();
						b = rand_word();
						amt = rand_amt(w[0]);
						rd = rand_reg();
						r = model_shift(w[0], shift_e'(k), amt, b);
						if (n != 0)
							r = ~r;
						case (opc)
							1: r = a | r;
							2: r = a ^ r;
							default: r = a & r;
						endcase
						if (w == 0)
							r[63:32] = '0;
						f = '0;  // c and v always clear
						f.n = (w != 0) ? r[63] : r[31];
						f.z = (r == '0);
						run_inst($sformatf("logic w%0d opc%0d n%0d k%0d", w, opc, n, k),
							enc_logic(w[0], 2'(opc), shift_e'(k), n[0], amt, rd), rd, w[0],
							a, b, 1'b1, r, opc == 3, f);
					end
				end
			end
		end
		report_test("logical", e0);
	endtask

	task automatic test_move();
		int e0;
		logic [15:0] imm;
		xword_t r;
		reg_addr_t rd;
		e0 = errors;
		for (int w = 0; w < 2; w++) begin
			for (int m = 0; m < 2; m++) begin
				for (int hw = 0; hw < ((w != 0) ? 4 : 2); hw++) begin
					imm = 16'($urandom);
					rd = rand_reg();
					r = '0;
					r[16 * hw +: 16] = imm;
					if (m == 0)
						r = ~r;  // MOVN
					if (w == 0)
						r[63:32] = '0;
					run_inst($sformatf("move w%0d movz%0d hw%0d", w, m, hw),
						enc_move(w[0], (m != 0) ? 2'b10 : 2'b00, 2'(hw), imm, rd), rd, w[0],
						rand_word(), rand_word(), 1'b1, r, 1'b0, '0);
				end
			end
		end
		report_test("move wide", e0);
	endtask

	task automatic test_unsupported();
		int e0;
		inst_t bad [8];
		e0 = errors;
		arith_reg("subs setup", 1'b1, 1'b1, 1'b1, SHIFT_LSL, 6'd0, 64'd7, 64'd7);  // flags nonzero
		bad[0] = 32'hf940_0041;  // ldr x1, [x2]
		bad[1] = 32'h1400_0010;  // b
		bad[2] = enc_logic(1'b0, 2'b01, SHIFT_LSL, 1'b0, 6'd32, 5'd3);
		bad[3] = enc_addsub_reg(1'b0, 1'b0, 1'b1, SHIFT_LSL, 6'd40, 5'd4);
		bad[4] = enc_addsub_reg(1'b1, 1'b1, 1'b1, SHIFT_ROR, 6'd3, 5'd5);
		bad[5] = enc_move(1'b1, 2'b11, 2'd0, 16'h1234, 5'd6);  // movk
		bad[6] = enc_move(1'b0, 2'b10, 2'd2, 16'h5678, 5'd7);
		bad[7] = {3'b101, 5'b01011, 3'b001, 5'd2, 6'd0, 5'd1, 5'd8};  // adds extended
		for (int j = 0; j < 8; j++)
			run_inst($sformatf("unsupported %0d", j), bad[j], 5'd0, 1'b0, rand_word(),
				rand_word(), 1'b0, '0, 1'b0, '0);
		report_test("unsupported", e0);
	endtask

	initial begin
		rst = 1'b1;
		inst = '0;
		rn_val = '0;
		rm_val = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(25081));
		repeat (8) @(posedge clock);
		#5;
		rst = 1'b0;
		test_reset();
		test_add_sub();
		test_flag_set();
		test_logic();
		test_move();
		test_unsupported();
		if (exec_stage_i.merge_i.asserts_i.failures != 0) begin
			$display("bound assertions failed %0d times",
				exec_stage_i.merge_i.asserts_i.failures);
			errors += exec_stage_i.merge_i.asserts_i.failures;
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		#(watchdog_time);
		$display("timeout: the tests did not finish within %0d time units", watchdog_time);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/a64_isa_pkg.sv
hw/exec_pkg.sv
hw/unit_result_if.sv
hw/inst_decode.sv
hw/arith_unit.sv
hw/logic_unit.sv
hw/result_merge.sv
hw/exec_stage.sv
tb/clock_gen.sv
tb/exec_stage_asserts.sv
tb/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_stage_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vexec_stage_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1
